//--- cpu.f
rv32i_pkg.sv
fetch_unit.sv
instruction_queue.sv
decoder.sv
regfile.sv
alu_rs.sv
reorder_buffer.sv
cpu.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - rv32i_pkg.sv
  - fetch_unit.sv
  - instruction_queue.sv
  - decoder.sv
  - regfile.sv
  - alu_rs.sv
  - reorder_buffer.sv
  - cpu.sv
  - target: simulation
    files:
      - tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ns
// testbench for the out-of-order RV32I core
// random 48-instruction program over x0..x7, memory answers after 0..4 cycles
// addresses past the program read ADDI x0, x0, 0
// golden model runs the program in order before reset is released
// the run goes on through a couple of filler no-ops after the program
module tb_cpu import rv32i_pkg::*; ();

    localparam int        PROG_LEN          = 48;
    localparam int        FILLER_COMMITS    = 2;
    localparam int        FIRST_REQ_TIMEOUT = 20;
    localparam int        COMMIT_TIMEOUT    = 2000;
    localparam int        MAX_MEM_DELAY     = 4;
    localparam int        DELAY_TAB_LEN     = 64;
    localparam rv32i_word NOP_INST          = 32'h0000_0013;

    logic      clk;
    logic      rst_n_i;
    logic      mem_resp_i;
    rv32i_word mem_rdata_i;
    logic      mem_read_o;
    rv32i_word mem_address_o;
    logic      commit_valid_o;
    rv32i_word commit_pc_o;
    rv32i_reg  commit_rd_o;
    rv32i_word commit_value_o;

    rv32i_word program_mem [PROG_LEN];
    rv32i_word exp_value   [PROG_LEN];
    rv32i_reg  exp_rd      [PROG_LEN];
    rv32i_word golden_regs [32];
    int        mem_delay   [DELAY_TAB_LEN];
    rv32i_word next_req_addr = RESET_PC;
    int        commit_count  = 0;
    int        delay_left    = -1;
    int        req_index     = 0;
    int        cycles        = 0;
    int        checks        = 0;
    int        errors        = 0;
    logic      rst_prev      = 1'b0;
    logic      timed_out     = 1'b0;

    cpu uut (
        .clk(clk), .rst_n_i(rst_n_i),
        .mem_resp_i(mem_resp_i), .mem_rdata_i(mem_rdata_i),
        .mem_read_o(mem_read_o), .mem_address_o(mem_address_o),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_rd_o(commit_rd_o), .commit_value_o(commit_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reference RV32I integer semantics
    function automatic rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                          input rv32i_word a, input rv32i_word b);
        case (f3)
            3'd0: begin
                if (alt)
                    return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic rv32i_word golden_result(input rv32i_word inst, input rv32i_word pc);
        rv32i_word  a;
        rv32i_word  imm;
        logic [2:0] f3;
        a   = golden_regs[inst[19:15]];
        f3  = inst[14:12];
        imm = {{20{inst[31]}}, inst[31:20]};
        case (inst[6:0])
            OPC_OP:     return alu_ref(f3, inst[30], a, golden_regs[inst[24:20]]);
            OPC_OP_IMM: return alu_ref(f3, inst[30] && f3 == 3'd5, a, imm);
            OPC_LUI:    return {inst[31:12], 12'b0};
            default:    return pc + {inst[31:12], 12'b0};
        endcase
    endfunction

    function automatic rv32i_word random_instruction();
        rv32i_reg   rd;
        rv32i_reg   rs1;
        rv32i_reg   rs2;
        logic [2:0] f3;
        logic       alt;
        logic [6:0] f7;
        int         kind;
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        alt  = 1'($urandom_range(0, 1));
        kind = $urandom_range(0, 9);
        // funct7 only carries SUB or SRA
        f7   = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
        if (kind < 4)
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        if (kind < 8) begin
            if (f3 == 3'd1 || f3 == 3'd5)
                return {f7, 5'($urandom_range(0, 31)), rs1, f3, rd, OPC_OP_IMM};
            return {12'($urandom), rs1, f3, rd, OPC_OP_IMM};
        end
        if (kind == 8)
            return {20'($urandom), rd, OPC_LUI};
        return {20'($urandom), rd, OPC_AUIPC};
    endfunction

    task automatic build_program();
        rv32i_word pc;
        for (int r = 0; r < 32; r++)
            golden_regs[r] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            pc             = RESET_PC + 32'(4 * i);
            program_mem[i] = random_instruction();
            exp_rd[i]      = program_mem[i][11:7];
            exp_value[i]   = golden_result(program_mem[i], pc);
            if (exp_rd[i] != '0)
                golden_regs[exp_rd[i]] = exp_value[i];
        end
    endtask

    // response delays drawn once, repeating every DELAY_TAB_LEN requests
    task automatic draw_mem_delays();
        for (int i = 0; i < DELAY_TAB_LEN; i++)
            mem_delay[i] = $urandom_range(0, MAX_MEM_DELAY);
    endtask

    function automatic rv32i_word fetch_word(input rv32i_word addr);
        if (addr[31:2] < PROG_LEN)
            return program_mem[addr[31:2]];
        return NOP_INST;
    endfunction

    // instruction memory with a random response delay
    always @(posedge clk) begin
        if (!rst_n_i) begin
            mem_resp_i <= 1'b0;
            delay_left = -1;
        end else begin
            mem_resp_i <= 1'b0;
            if (mem_read_o && !mem_resp_i) begin
                if (delay_left < 0) begin
                    delay_left = mem_delay[req_index % DELAY_TAB_LEN];
                    req_index++;
                end
                if (delay_left == 0) begin
                    mem_resp_i  <= 1'b1;
                    mem_rdata_i <= fetch_word(mem_address_o);
                    delay_left = -1;
                end else
                    delay_left--;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_read_o && !mem_resp_i |=> mem_read_o && $stable(mem_address_o))
    else begin
        errors++;
        $display("fetch request dropped or address changed before the response");
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_o |-> !$isunknown({commit_pc_o, commit_rd_o, commit_value_o}))
    else begin
        errors++;
        $display("commit trace carries unknown bits");
    end

    always @(posedge clk) begin
        // first edge skipped, flops only settle there
        if (cycles > 0 && (!rst_n_i || !rst_prev)) begin
            assert (!mem_read_o && !commit_valid_o) else begin
                errors++;
                $display("FAILED mem_read_o 0x%0h commit_valid_o 0x%0h expected 0x0 in reset",
                         mem_read_o, commit_valid_o);
            end
        end
        if (rst_n_i && mem_read_o) begin
            assert (mem_address_o == next_req_addr) else begin
                errors++;
                $display("FAILED mem_address_o got 0x%08h expected 0x%08h",
                         mem_address_o, next_req_addr);
            end
            if (mem_resp_i)
                next_req_addr = next_req_addr + 32'd4;
        end
        if (rst_n_i && commit_valid_o) begin
            checks++;
            assert (commit_pc_o == RESET_PC + 32'(4 * commit_count)) else begin
                errors++;
                $display("FAILED commit_pc_o got 0x%08h expected 0x%08h",
                         commit_pc_o, RESET_PC + 32'(4 * commit_count));
            end
            if (commit_count < PROG_LEN) begin
                assert (commit_rd_o == exp_rd[commit_count]) else begin
                    errors++;
                    $display("FAILED commit_rd_o got 0x%02h expected 0x%02h",
                             commit_rd_o, exp_rd[commit_count]);
                end
                if (exp_rd[commit_count] != '0) begin
                    assert (commit_value_o == exp_value[commit_count]) else begin
                        errors++;
                        $display("FAILED commit_value_o got 0x%08h expected 0x%08h",
                                 commit_value_o, exp_value[commit_count]);
                    end
                end
            end else begin
                // filler no-op past the program
                assert (commit_rd_o == '0) else begin
                    errors++;
                    $display("FAILED commit_rd_o got 0x%02h expected 0x00", commit_rd_o);
                end
            end
            commit_count++;
        end
        rst_prev = rst_n_i;
        cycles++;
    end

    task automatic wait_first_request();
        int n;
        n = 0;
        while (!mem_read_o && n < FIRST_REQ_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!mem_read_o) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout while waiting for the first fetch request");
        end
    endtask

    task automatic wait_all_commits();
        int n;
        n = 0;
        while (commit_count < PROG_LEN + FILLER_COMMITS && n < COMMIT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (commit_count < PROG_LEN + FILLER_COMMITS) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout with %0d of %0d instructions committed", commit_count,
                     PROG_LEN + FILLER_COMMITS);
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        mem_resp_i  = 1'b0;
        mem_rdata_i = '0;
        void'($urandom(32'h7552_c8a9));
        build_program();
        draw_mem_delays();
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        wait_first_request();
        if (!timed_out)
            wait_all_commits();
        @(negedge clk);
        $display("commits checked %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ns
// top level of the out-of-order RV32I integer core
// read-only instruction port, request held until mem_resp_i
// commit trace is a registered copy of the ROB commit
// no branches, loads or stores
module cpu import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      mem_resp_i,
    input  rv32i_word mem_rdata_i,
    output logic      mem_read_o,
    output rv32i_word mem_address_o,
    output logic      commit_valid_o,
    output rv32i_word commit_pc_o,
    output rv32i_reg  commit_rd_o,
    output rv32i_word commit_value_o
);

    logic      iq_ready, iq_push, iq_valid, iq_shift;
    rv32i_word iq_pc, iq_inst, dec_pc, dec_inst;

    logic      rs1_busy, rs2_busy, rename;
    rv32i_reg  rs1, rs2, rename_rd;
    rv32i_word rs1_value, rs2_value;
    tag_t      rs1_tag, rs2_tag, rename_tag;

    logic      rob_ready, alloc_valid, lookup1_ready, lookup2_ready;
    tag_t      alloc_tag, lookup1_tag, lookup2_tag;
    rv32i_reg  alloc_rd;
    rv32i_word alloc_pc, lookup1_value, lookup2_value;

    logic      commit;
    rv32i_reg  commit_rd;
    tag_t      commit_tag;
    rv32i_word commit_value, commit_pc;

    logic      rs_ready, dispatch_valid, opa_valid, opb_valid, cdb_valid;
    alu_op_t   dispatch_op;
    tag_t      dispatch_tag, opa_tag, opb_tag, cdb_tag;
    rv32i_word opa_value, opb_value, cdb_value;

    fetch_unit fetch_unit_inst (
        .clk(clk), .rst_n_i(rst_n_i), .iq_ready_i(iq_ready),
        .mem_resp_i(mem_resp_i), .mem_rdata_i(mem_rdata_i),
        .mem_read_o(mem_read_o), .mem_address_o(mem_address_o),
        .iq_push_o(iq_push), .iq_pc_o(iq_pc), .iq_inst_o(iq_inst)
    );

    instruction_queue instruction_queue_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .push_i(iq_push), .pc_i(iq_pc), .inst_i(iq_inst),
        .shift_i(iq_shift), .ready_o(iq_ready),
        .valid_o(iq_valid), .pc_o(dec_pc), .inst_o(dec_inst)
    );

    decoder decoder_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .iq_valid_i(iq_valid), .iq_pc_i(dec_pc), .iq_inst_i(dec_inst),
        .iq_shift_o(iq_shift),
        // regfile side
        .rs1_o(rs1), .rs2_o(rs2),
        .rs1_value_i(rs1_value), .rs1_busy_i(rs1_busy), .rs1_tag_i(rs1_tag),
        .rs2_value_i(rs2_value), .rs2_busy_i(rs2_busy), .rs2_tag_i(rs2_tag),
        .rename_o(rename), .rename_rd_o(rename_rd), .rename_tag_o(rename_tag),
        // ROB side
        .rob_ready_i(rob_ready), .alloc_tag_i(alloc_tag),
        .alloc_valid_o(alloc_valid), .alloc_rd_o(alloc_rd), .alloc_pc_o(alloc_pc),
        .lookup1_tag_o(lookup1_tag), .lookup1_ready_i(lookup1_ready),
        .lookup1_value_i(lookup1_value),
        .lookup2_tag_o(lookup2_tag), .lookup2_ready_i(lookup2_ready),
        .lookup2_value_i(lookup2_value),
        // station side
        .rs_ready_i(rs_ready), .dispatch_valid_o(dispatch_valid),
        .dispatch_op_o(dispatch_op), .dispatch_tag_o(dispatch_tag),
        .opa_valid_o(opa_valid), .opa_value_o(opa_value), .opa_tag_o(opa_tag),
        .opb_valid_o(opb_valid), .opb_value_o(opb_value), .opb_tag_o(opb_tag)
    );

    regfile regfile_inst (
        .clk(clk), .rst_n_i(rst_n_i), .rs1_i(rs1), .rs2_i(rs2),
        .rs1_value_o(rs1_value), .rs1_busy_o(rs1_busy), .rs1_tag_o(rs1_tag),
        .rs2_value_o(rs2_value), .rs2_busy_o(rs2_busy), .rs2_tag_o(rs2_tag),
        .rename_i(rename), .rename_rd_i(rename_rd), .rename_tag_i(rename_tag),
        .commit_i(commit), .commit_rd_i(commit_rd), .commit_tag_i(commit_tag),
        .commit_value_i(commit_value)
    );

    alu_rs alu_rs_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .dispatch_valid_i(dispatch_valid), .dispatch_op_i(dispatch_op),
        .dispatch_tag_i(dispatch_tag),
        .opa_valid_i(opa_valid), .opa_value_i(opa_value), .opa_tag_i(opa_tag),
        .opb_valid_i(opb_valid), .opb_value_i(opb_value), .opb_tag_i(opb_tag),
        .rs_ready_o(rs_ready),
        .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_value_o(cdb_value)
    );

    reorder_buffer rob_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .alloc_valid_i(alloc_valid), .alloc_rd_i(alloc_rd), .alloc_pc_i(alloc_pc),
        .rob_ready_o(rob_ready), .alloc_tag_o(alloc_tag),
        .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_value_i(cdb_value),
        .lookup1_tag_i(lookup1_tag), .lookup1_ready_o(lookup1_ready),
        .lookup1_value_o(lookup1_value),
        .lookup2_tag_i(lookup2_tag), .lookup2_ready_o(lookup2_ready),
        .lookup2_value_o(lookup2_value),
        .commit_o(commit), .commit_rd_o(commit_rd), .commit_tag_o(commit_tag),
        .commit_value_o(commit_value), .commit_pc_o(commit_pc)
    );

    // retirement trace
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            commit_valid_o <= 1'b0;
        else
            commit_valid_o <= commit;
    end

    always_ff @(posedge clk) begin
        commit_pc_o    <= commit_pc;
        commit_rd_o    <= commit_rd;
        commit_value_o <= commit_value;
    end

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ns
// in-order result buffer, tag is the slot index
// lookups see a CDB result in the same cycle it is broadcast
// the head commits once done, one entry per cycle
module reorder_buffer import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      alloc_valid_i,
    input  rv32i_reg  alloc_rd_i,
    input  rv32i_word alloc_pc_i,
    output logic      rob_ready_o,
    output tag_t      alloc_tag_o,
    input  logic      cdb_valid_i,
    input  tag_t      cdb_tag_i,
    input  rv32i_word cdb_value_i,
    input  tag_t      lookup1_tag_i,
    output logic      lookup1_ready_o,
    output rv32i_word lookup1_value_o,
    input  tag_t      lookup2_tag_i,
    output logic      lookup2_ready_o,
    output rv32i_word lookup2_value_o,
    output logic      commit_o,
    output rv32i_reg  commit_rd_o,
    output tag_t      commit_tag_o,
    output rv32i_word commit_value_o,
    output rv32i_word commit_pc_o
);

    rv32i_reg  rd_q    [ROB_DEPTH];
    rv32i_word pc_q    [ROB_DEPTH];
    rv32i_word value_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0]           done_q;
    tag_t                           head_q;
    tag_t                           tail_q;
    logic [$clog2(ROB_DEPTH+1)-1:0] count_q;

    assign rob_ready_o = count_q < ROB_DEPTH;
    assign alloc_tag_o = tail_q;

    assign commit_o       = (count_q != '0) && done_q[head_q];
    assign commit_rd_o    = rd_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_value_o = value_q[head_q];
    assign commit_pc_o    = pc_q[head_q];

    // a done entry never matches the CDB again
    assign lookup1_ready_o = done_q[lookup1_tag_i] || (cdb_valid_i && cdb_tag_i == lookup1_tag_i);
    assign lookup1_value_o = done_q[lookup1_tag_i] ? value_q[lookup1_tag_i] : cdb_value_i;
    assign lookup2_ready_o = done_q[lookup2_tag_i] || (cdb_valid_i && cdb_tag_i == lookup2_tag_i);
    assign lookup2_value_o = done_q[lookup2_tag_i] ? value_q[lookup2_tag_i] : cdb_value_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_valid_i) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (cdb_valid_i)
                done_q[cdb_tag_i] <= 1'b1;
            if (commit_o)
                head_q <= head_q + 1'b1;
            count_q <= count_q + alloc_valid_i - commit_o;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            rd_q[tail_q] <= alloc_rd_i;
            pc_q[tail_q] <= alloc_pc_i;
        end
        if (cdb_valid_i)
            value_q[cdb_tag_i] <= cdb_value_i;
    end

endmodule

//--- alu_rs.sv
`timescale 1ns/1ns
// ALU reservation station with the ALU and the CDB driver
// entries stay compacted, index 0 is the oldest
// rs_ready_o already counts the dispatch arriving this cycle
// one result per cycle on the CDB, registered after issue
module alu_rs import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      dispatch_valid_i,
    input  alu_op_t   dispatch_op_i,
    input  tag_t      dispatch_tag_i,
    input  logic      opa_valid_i,
    input  rv32i_word opa_value_i,
    input  tag_t      opa_tag_i,
    input  logic      opb_valid_i,
    input  rv32i_word opb_value_i,
    input  tag_t      opb_tag_i,
    output logic      rs_ready_o,
    output logic      cdb_valid_o,
    output tag_t      cdb_tag_o,
    output rv32i_word cdb_value_o
);

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        tag_t      tag;
        logic      a_valid;
        rv32i_word a_value;
        tag_t      a_tag;
        logic      b_valid;
        rv32i_word b_value;
        tag_t      b_tag;
    } rs_entry_t;

    rs_entry_t entries_q [RS_DEPTH];
    rs_entry_t entries_d [RS_DEPTH];
    rs_entry_t new_entry;
    rs_entry_t issued;
    logic      issue_valid;
    int        issue_idx;
    int        occupied;
    rv32i_word alu_result;

    // pick up a missing operand from the CDB
    function automatic rs_entry_t snoop(input rs_entry_t e);
        rs_entry_t r;
        r = e;
        if (cdb_valid_o && !r.a_valid && r.a_tag == cdb_tag_o) begin
            r.a_valid = 1'b1;
            r.a_value = cdb_value_o;
        end
        if (cdb_valid_o && !r.b_valid && r.b_tag == cdb_tag_o) begin
            r.b_valid = 1'b1;
            r.b_value = cdb_value_o;
        end
        return r;
    endfunction

    assign new_entry = '{valid: 1'b1, op: dispatch_op_i, tag: dispatch_tag_i,
                         a_valid: opa_valid_i, a_value: opa_value_i, a_tag: opa_tag_i,
                         b_valid: opb_valid_i, b_value: opb_value_i, b_tag: opb_tag_i};

    always_comb begin
        occupied    = 0;
        issue_valid = 1'b0;
        issue_idx   = 0;
        // reverse scan so the lowest ready index wins
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (entries_q[i].valid)
                occupied++;
            if (entries_q[i].valid && entries_q[i].a_valid && entries_q[i].b_valid) begin
                issue_valid = 1'b1;
                issue_idx   = i;
            end
        end
    end

    assign rs_ready_o = (occupied + int'(dispatch_valid_i)) < RS_DEPTH;
    assign issued     = entries_q[issue_idx];

    always_comb begin
        int count;
        count = 0;
        for (int i = 0; i < RS_DEPTH; i++)
            entries_d[i] = '0;
        // drop the issued entry and close the gap
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (entries_q[i].valid && !(issue_valid && i == issue_idx)) begin
                entries_d[count] = snoop(entries_q[i]);
                count++;
            end
        end
        if (dispatch_valid_i && count < RS_DEPTH)
            entries_d[count] = snoop(new_entry);
    end

    always_comb begin
        case (issued.op)
            ALU_ADD:  alu_result = issued.a_value + issued.b_value;
            ALU_SUB:  alu_result = issued.a_value - issued.b_value;
            ALU_SLL:  alu_result = issued.a_value << issued.b_value[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(issued.a_value) < $signed(issued.b_value)};
            ALU_SLTU: alu_result = {31'b0, issued.a_value < issued.b_value};
            ALU_XOR:  alu_result = issued.a_value ^ issued.b_value;
            ALU_SRL:  alu_result = issued.a_value >> issued.b_value[4:0];
            ALU_SRA:  alu_result = $signed(issued.a_value) >>> issued.b_value[4:0];
            ALU_OR:   alu_result = issued.a_value | issued.b_value;
            ALU_AND:  alu_result = issued.a_value & issued.b_value;
            // pass-B for LUI
            default:  alu_result = issued.b_value;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++)
                entries_q[i] <= '0;
        end else begin
            cdb_valid_o <= issue_valid;
            entries_q   <= entries_d;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_o   <= issued.tag;
        cdb_value_o <= alu_result;
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ns
// architectural registers with busy flag and producer tag
// x0 reads zero and is never written or renamed
// a rename in the commit cycle wins over the busy clear
module regfile import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  rv32i_reg  rs1_i,
    input  rv32i_reg  rs2_i,
    output rv32i_word rs1_value_o,
    output logic      rs1_busy_o,
    output tag_t      rs1_tag_o,
    output rv32i_word rs2_value_o,
    output logic      rs2_busy_o,
    output tag_t      rs2_tag_o,
    input  logic      rename_i,
    input  rv32i_reg  rename_rd_i,
    input  tag_t      rename_tag_i,
    input  logic      commit_i,
    input  rv32i_reg  commit_rd_i,
    input  tag_t      commit_tag_i,
    input  rv32i_word commit_value_i
);

    rv32i_word   value_q [32];
    tag_t        tag_q   [32];
    logic [31:0] busy_q;

    assign rs1_value_o = value_q[rs1_i];
    assign rs1_busy_o  = busy_q[rs1_i];
    assign rs1_tag_o   = tag_q[rs1_i];
    assign rs2_value_o = value_q[rs2_i];
    assign rs2_busy_o  = busy_q[rs2_i];
    assign rs2_tag_o   = tag_q[rs2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < 32; i++) begin
                value_q[i] <= '0;
                tag_q[i]   <= '0;
            end
        end else begin
            if (commit_i && commit_rd_i != '0) begin
                value_q[commit_rd_i] <= commit_value_i;
                // only the youngest producer frees the register
                if (tag_q[commit_rd_i] == commit_tag_i)
                    busy_q[commit_rd_i] <= 1'b0;
            end
            if (rename_i && rename_rd_i != '0) begin
                busy_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]  <= rename_tag_i;
            end
        end
    end

endmodule

//--- decoder.sv
`timescale 1ns/1ns
// decode, rename and dispatch of one instruction per cycle
// operands resolve combinationally from the regfile or the ROB lookups,
// and the ROB slot and rename happen in the dispatch cycle
// the station sees the instruction one clock later from the output register
// unsupported encodings become a no-op writing x0
module decoder import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      iq_valid_i,
    input  rv32i_word iq_pc_i,
    input  rv32i_word iq_inst_i,
    output logic      iq_shift_o,
    output rv32i_reg  rs1_o,
    output rv32i_reg  rs2_o,
    input  rv32i_word rs1_value_i,
    input  logic      rs1_busy_i,
    input  tag_t      rs1_tag_i,
    input  rv32i_word rs2_value_i,
    input  logic      rs2_busy_i,
    input  tag_t      rs2_tag_i,
    output logic      rename_o,
    output rv32i_reg  rename_rd_o,
    output tag_t      rename_tag_o,
    input  logic      rob_ready_i,
    input  tag_t      alloc_tag_i,
    output logic      alloc_valid_o,
    output rv32i_reg  alloc_rd_o,
    output rv32i_word alloc_pc_o,
    output tag_t      lookup1_tag_o,
    input  logic      lookup1_ready_i,
    input  rv32i_word lookup1_value_i,
    output tag_t      lookup2_tag_o,
    input  logic      lookup2_ready_i,
    input  rv32i_word lookup2_value_i,
    input  logic      rs_ready_i,
    output logic      dispatch_valid_o,
    output alu_op_t   dispatch_op_o,
    output tag_t      dispatch_tag_o,
    output logic      opa_valid_o,
    output rv32i_word opa_value_o,
    output tag_t      opa_tag_o,
    output logic      opb_valid_o,
    output rv32i_word opb_value_o,
    output tag_t      opb_tag_o
);

    logic [6:0] opcode;
    rv32i_word  imm_i;
    rv32i_word  imm_u;
    logic       use_rs1;
    logic       use_rs2;
    logic       go;
    alu_op_t    op;
    rv32i_reg   dest;
    logic       a_valid;
    rv32i_word  a_value;
    logic       b_valid;
    rv32i_word  b_value;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic reg_form);
        case (f3)
            3'b000:  return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = iq_inst_i[6:0];
    assign imm_i  = {{20{iq_inst_i[31]}}, iq_inst_i[31:20]};
    assign imm_u  = {iq_inst_i[31:12], 12'b0};
    assign rs1_o  = iq_inst_i[19:15];
    assign rs2_o  = iq_inst_i[24:20];

    assign lookup1_tag_o = rs1_tag_i;
    assign lookup2_tag_o = rs2_tag_i;

    always_comb begin
        op      = ALU_ADD;
        dest    = iq_inst_i[11:7];
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op      = alu_decode(iq_inst_i[14:12], iq_inst_i[30], 1'b1);
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                op      = alu_decode(iq_inst_i[14:12], iq_inst_i[30], 1'b0);
            end
            OPC_LUI:   op = ALU_PASSB;
            OPC_AUIPC: op = ALU_ADD;
            default:   dest = '0;
        endcase
    end

    // operand A: register, PC for AUIPC, else zero
    always_comb begin
        a_valid = 1'b1;
        a_value = '0;
        if (opcode == OPC_AUIPC)
            a_value = iq_pc_i;
        else if (use_rs1) begin
            if (!rs1_busy_i)
                a_value = rs1_value_i;
            else if (lookup1_ready_i)
                a_value = lookup1_value_i;
            else
                a_valid = 1'b0;
        end
    end

    // operand B: register, I-immediate or U-immediate
    always_comb begin
        b_valid = 1'b1;
        b_value = '0;
        if (use_rs2) begin
            if (!rs2_busy_i)
                b_value = rs2_value_i;
            else if (lookup2_ready_i)
                b_value = lookup2_value_i;
            else
                b_valid = 1'b0;
        end else if (opcode == OPC_OP_IMM)
            b_value = imm_i;
        else if (opcode == OPC_LUI || opcode == OPC_AUIPC)
            b_value = imm_u;
    end

    assign go            = iq_valid_i && rob_ready_i && rs_ready_i;
    assign iq_shift_o    = go;
    assign alloc_valid_o = go;
    assign alloc_rd_o    = dest;
    assign alloc_pc_o    = iq_pc_i;
    // x0 never gets a producer tag
    assign rename_o      = go && (dest != '0);
    assign rename_rd_o   = dest;
    assign rename_tag_o  = alloc_tag_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            dispatch_valid_o <= 1'b0;
        else
            dispatch_valid_o <= go;
    end

    always_ff @(posedge clk) begin
        dispatch_op_o  <= op;
        dispatch_tag_o <= alloc_tag_i;
        opa_valid_o    <= a_valid;
        opa_value_o    <= a_value;
        opa_tag_o      <= rs1_tag_i;
        opb_valid_o    <= b_valid;
        opb_value_o    <= b_value;
        opb_tag_o      <= rs2_tag_i;
    end

endmodule

//--- instruction_queue.sv
`timescale 1ns/1ns
// circular FIFO between fetch and decode
// ready_o means a free slot exists for the single word in flight
// a push into a full queue is not expected, fetch respects ready_o
module instruction_queue import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      push_i,
    input  rv32i_word pc_i,
    input  rv32i_word inst_i,
    input  logic      shift_i,
    output logic      ready_o,
    output logic      valid_o,
    output rv32i_word pc_o,
    output rv32i_word inst_o
);

    rv32i_word pc_q   [IQ_DEPTH];
    rv32i_word inst_q [IQ_DEPTH];

    logic [$clog2(IQ_DEPTH)-1:0]   head_q;
    logic [$clog2(IQ_DEPTH)-1:0]   tail_q;
    logic [$clog2(IQ_DEPTH+1)-1:0] count_q;

    // count only drops while a fetch is outstanding
    assign ready_o = count_q < IQ_DEPTH;
    assign valid_o = count_q != '0;
    assign pc_o    = pc_q[head_q];
    assign inst_o  = inst_q[head_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i)
                tail_q <= tail_q + 1'b1;
            if (shift_i)
                head_q <= head_q + 1'b1;
            count_q <= count_q + push_i - shift_i;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_q[tail_q]   <= pc_i;
            inst_q[tail_q] <= inst_i;
        end
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ns
// instruction fetch, one outstanding read at a time
// address and read strobe hold until mem_resp_i
// no branches, so the PC only ever advances by 4
module fetch_unit import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      iq_ready_i,
    input  logic      mem_resp_i,
    input  rv32i_word mem_rdata_i,
    output logic      mem_read_o,
    output rv32i_word mem_address_o,
    output logic      iq_push_o,
    output rv32i_word iq_pc_o,
    output rv32i_word iq_inst_o
);

    rv32i_word pc_q;

    assign mem_address_o = pc_q;

    // returned word goes straight into the queue
    assign iq_push_o = mem_read_o && mem_resp_i;
    assign iq_pc_o   = pc_q;
    assign iq_inst_o = mem_rdata_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            mem_read_o <= 1'b0;
        end else if (mem_read_o) begin
            if (mem_resp_i) begin
                mem_read_o <= 1'b0;
                pc_q       <= pc_q + 32'd4;
            end
        end else if (iq_ready_i) begin
            // queue has a slot kept for this word
            mem_read_o <= 1'b1;
        end
    end

endmodule

//--- rv32i_pkg.sv
// shared types and sizing for the out-of-order RV32I core
// queue and buffer depths must stay powers of two, since the ring
// pointers wrap by plain overflow
// tag_t width follows ROB_DEPTH
package rv32i_pkg;

    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH  = 4;
    localparam int IQ_DEPTH  = 4;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;
    typedef logic [$clog2(ROB_DEPTH)-1:0] tag_t;

    localparam rv32i_word RESET_PC = 32'h0000_0000;

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } alu_op_t;

endpackage
